/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B  // pass_b for lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_e;

    typedef enum logic [1:0] {
        WB_NONE, WB_PC4, WB_ALU, WB_LOAD
    } wb_sel_e;

    typedef enum logic [2:0] {
        ST_FETCH_ADDR, ST_FETCH_DATA, ST_EXECUTE, ST_MEM_ADDR,
        ST_MEM_DATA, ST_WRITE_RESP, ST_RETIRE
    } state_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    a_sel_pc;   // operand a from pc
        logic    b_sel_imm;  // operand b from immediate
        branch_e branch;
        wb_sel_e wb_sel;
        logic    is_jal;
        logic    is_jalr;
        logic    is_load;
        logic    is_store;
        logic    reg_we;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] araddr;
        logic        arvalid;
        logic        rready;
        logic [31:0] awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
    } axil_req_t;

    typedef struct packed {
        logic        arready;
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rvalid;
        logic        awready;
        logic        wready;
        logic [1:0]  bresp;
        logic        bvalid;
    } axil_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [4:0]  rd;       // 0 when nothing written
        logic [31:0] rd_data;
    } retire_t;

endpackage

`default_nettype wire

/* logic/rv_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_decoder import rv_pkg::*; (
    input  logic [31:0] instr,
    output ctrl_t       ctrl,
    output logic [31:0] imm
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;  // instr[30], selects sub / sra

    // funct3 to alu operation, shared by op and op-imm
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub_en,
                                         input logic sra_en);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub_en ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = sra_en ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    always_comb begin
        ctrl = '0;  // unknown opcode retires as a no-op
        imm  = 32'd0;
        case (opcode)
            OPC_LUI: begin
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.b_sel_imm = 1'b1;
                ctrl.wb_sel    = WB_ALU;
                ctrl.reg_we    = 1'b1;
                imm            = {instr[31:12], 12'd0};
            end
            OPC_AUIPC: begin
                ctrl.a_sel_pc  = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.wb_sel    = WB_ALU;
                ctrl.reg_we    = 1'b1;
                imm            = {instr[31:12], 12'd0};
            end
            OPC_JAL: begin
                ctrl.a_sel_pc  = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.is_jal    = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                ctrl.reg_we    = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl.b_sel_imm = 1'b1;
                ctrl.is_jalr   = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                ctrl.reg_we    = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_BRANCH: begin
                ctrl.a_sel_pc  = 1'b1;  // target = pc + imm
                ctrl.b_sel_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl.branch = BR_EQ;
                    3'b001:  ctrl.branch = BR_NE;
                    3'b100:  ctrl.branch = BR_LT;
                    3'b101:  ctrl.branch = BR_GE;
                    3'b110:  ctrl.branch = BR_LTU;
                    3'b111:  ctrl.branch = BR_GEU;
                    default: ctrl.branch = BR_NONE;
                endcase
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin  // lw only
                    ctrl.b_sel_imm = 1'b1;
                    ctrl.is_load   = 1'b1;
                    ctrl.wb_sel    = WB_LOAD;
                    ctrl.reg_we    = 1'b1;
                    imm            = {{20{instr[31]}}, instr[31:20]};
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin  // sw only
                    ctrl.b_sel_imm = 1'b1;
                    ctrl.is_store  = 1'b1;
                    imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            OPC_OP_IMM: begin
                ctrl.alu_op    = arith_op(funct3, 1'b0, alt);
                ctrl.b_sel_imm = 1'b1;
                ctrl.wb_sel    = WB_ALU;
                ctrl.reg_we    = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_OP: begin
                ctrl.alu_op = arith_op(funct3, alt, alt);
                ctrl.wb_sel = WB_ALU;
                ctrl.reg_we = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* logic/rv_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [31:0] rs1,
    input  logic [31:0] rs2,
    input  alu_op_e     op,
    input  branch_e     branch,
    output logic [31:0] result,
    output logic        take
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'd0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = 32'd0;
        endcase
    end

    // branch compare runs beside the target adder
    assign lt_s = $signed(rs1) < $signed(rs2);
    assign lt_u = rs1 < rs2;

    always_comb begin
        case (branch)
            BR_EQ:   take = (rs1 == rs2);
            BR_NE:   take = (rs1 != rs2);
            BR_LT:   take = lt_s;
            BR_GE:   take = !lt_s;
            BR_LTU:  take = lt_u;
            BR_GEU:  take = !lt_u;
            default: take = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* logic/rv_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    input  logic [4:0]  rd_addr,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && rd_addr != 5'd0) begin  // x0 never written
            regs[rd_addr] <= wdata;
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // x0 stays zero through reset and every write
    x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
        (rs1_addr == 5'd0) |-> (rs1_data == 32'd0));

endmodule

`default_nettype wire

/* logic/rv_pc.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_pc #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        advance,
    input  logic        jump,
    input  logic [31:0] target,
    output logic [31:0] pc
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (advance) begin
            if (jump) begin
                pc <= {target[31:1], 1'b0};  // jalr clears bit 0
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    // only aligned targets are legal
    pc_word_aligned: assert property (@(posedge clk) disable iff (rst)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* logic/rv_control_fsm.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_control_fsm import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ctrl_t       ctrl,
    input  logic [31:0] pc,
    input  logic [31:0] alu_result,
    input  logic [31:0] store_data,
    input  axil_rsp_t   axil_rsp,
    output axil_req_t   axil_req,
    output logic        instr_we,
    output logic        load_we,
    output logic        reg_we,
    output logic        pc_advance
);

    state_e state, next_state;
    logic   arvalid_q, awvalid_q, wvalid_q;
    logic   aw_done, w_done;      // channel accepted in this store
    logic   aw_done_n, w_done_n;
    logic   rready, bready;
    logic   ar_hs, r_hs, aw_hs, w_hs, b_hs;

    assign rready = (state == ST_FETCH_DATA) || (state == ST_MEM_DATA);
    assign bready = (state == ST_WRITE_RESP);

    assign ar_hs = arvalid_q && axil_rsp.arready;
    assign r_hs  = rready && axil_rsp.rvalid;
    assign aw_hs = awvalid_q && axil_rsp.awready;
    assign w_hs  = wvalid_q && axil_rsp.wready;
    assign b_hs  = bready && axil_rsp.bvalid;

    assign aw_done_n = aw_done || aw_hs;
    assign w_done_n  = w_done || w_hs;

    always_comb begin
        next_state = state;
        case (state)
            ST_FETCH_ADDR: if (ar_hs) next_state = ST_FETCH_DATA;
            ST_FETCH_DATA: if (r_hs) next_state = ST_EXECUTE;
            ST_EXECUTE: begin
                if (ctrl.is_load || ctrl.is_store) begin
                    next_state = ST_MEM_ADDR;
                end else begin
                    next_state = ST_RETIRE;
                end
            end
            ST_MEM_ADDR: begin
                if (ctrl.is_load) begin
                    if (ar_hs) next_state = ST_MEM_DATA;
                end else if (aw_done_n && w_done_n) begin
                    next_state = ST_WRITE_RESP;
                end
            end
            ST_MEM_DATA:   if (r_hs) next_state = ST_RETIRE;
            ST_WRITE_RESP: if (b_hs) next_state = ST_RETIRE;
            ST_RETIRE:     next_state = ST_FETCH_ADDR;
            default:       next_state = ST_FETCH_ADDR;
        endcase
    end

    // valids come from the next state so they are glitch free
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_FETCH_ADDR;
            arvalid_q <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            aw_done   <= 1'b0;
            w_done    <= 1'b0;
        end else begin
            state     <= next_state;
            arvalid_q <= (next_state == ST_FETCH_ADDR) ||
                         (next_state == ST_MEM_ADDR && ctrl.is_load);
            awvalid_q <= (next_state == ST_MEM_ADDR) && ctrl.is_store && !aw_done_n;
            wvalid_q  <= (next_state == ST_MEM_ADDR) && ctrl.is_store && !w_done_n;
            aw_done   <= (next_state == ST_MEM_ADDR) && aw_done_n;
            w_done    <= (next_state == ST_MEM_ADDR) && w_done_n;
        end
    end

    always_comb begin
        axil_req.araddr  = (state == ST_MEM_ADDR) ? alu_result : pc;
        axil_req.arvalid = arvalid_q;
        axil_req.rready  = rready;
        axil_req.awaddr  = alu_result;
        axil_req.awvalid = awvalid_q;
        axil_req.wdata   = store_data;
        axil_req.wstrb   = 4'hf;  // word stores only
        axil_req.wvalid  = wvalid_q;
        axil_req.bready  = bready;
    end

    assign instr_we   = (state == ST_FETCH_DATA) && r_hs;
    assign load_we    = (state == ST_MEM_DATA) && r_hs;
    assign reg_we     = (state == ST_RETIRE) && ctrl.reg_we;
    assign pc_advance = (state == ST_RETIRE);

    ar_held: assert property (@(posedge clk) disable iff (rst)
        arvalid_q && !axil_rsp.arready |=> arvalid_q && $stable(axil_req.araddr));

    aw_held: assert property (@(posedge clk) disable iff (rst)
        awvalid_q && !axil_rsp.awready |=> awvalid_q && $stable(axil_req.awaddr));

endmodule

`default_nettype wire

/* logic/rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_top import rv_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst,
    input  axil_rsp_t axil_rsp,
    output axil_req_t axil_req,
    output retire_t   retire
);

    logic [31:0] instr_q;   // latched instruction
    logic [31:0] load_q;    // latched lw data
    logic [31:0] pc, pc_plus4;
    logic [31:0] imm;
    ctrl_t       ctrl;
    logic [31:0] rs1_data, rs2_data;
    logic [31:0] alu_a, alu_b, alu_out;
    logic        take, jump;
    logic [31:0] wb_data;
    logic        instr_we, load_we, reg_we, pc_advance;

    always_ff @(posedge clk) begin
        if (instr_we) instr_q <= axil_rsp.rdata;
        if (load_we) load_q <= axil_rsp.rdata;
    end

    assign alu_a    = ctrl.a_sel_pc ? pc : rs1_data;
    assign alu_b    = ctrl.b_sel_imm ? imm : rs2_data;
    assign pc_plus4 = pc + 32'd4;
    assign jump     = ctrl.is_jal || ctrl.is_jalr || take;

    always_comb begin
        case (ctrl.wb_sel)
            WB_PC4:  wb_data = pc_plus4;  // link address
            WB_ALU:  wb_data = alu_out;
            WB_LOAD: wb_data = load_q;
            default: wb_data = 32'd0;
        endcase
    end

    rv_decoder rv_decoder_i (
        .instr (instr_q),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    rv_alu rv_alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .rs1    (rs1_data),
        .rs2    (rs2_data),
        .op     (ctrl.alu_op),
        .branch (ctrl.branch),
        .result (alu_out),
        .take   (take)
    );

    rv_regfile rv_regfile_i (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (instr_q[19:15]),
        .rs2_addr (instr_q[24:20]),
        .rd_addr  (instr_q[11:7]),
        .we       (reg_we),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_pc #(.RESET_PC(RESET_PC)) rv_pc_i (
        .clk     (clk),
        .rst     (rst),
        .advance (pc_advance),
        .jump    (jump),
        .target  (alu_out),
        .pc      (pc)
    );

    rv_control_fsm rv_control_fsm_i (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .pc         (pc),
        .alu_result (alu_out),
        .store_data (rs2_data),
        .axil_rsp   (axil_rsp),
        .axil_req   (axil_req),
        .instr_we   (instr_we),
        .load_we    (load_we),
        .reg_we     (reg_we),
        .pc_advance (pc_advance)
    );

    // trace of each finished instruction
    always_comb begin
        retire.valid   = pc_advance;
        retire.pc      = pc;
        retire.instr   = instr_q;
        retire.rd      = reg_we ? instr_q[11:7] : 5'd0;
        retire.rd_data = (retire.rd != 5'd0) ? wb_data : 32'd0;
    end

endmodule

`default_nettype wire

/* verification/rv_iss_model.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_iss_model import rv_pkg::*; #(
    parameter int N_INSTR = 200
) ();

    logic [31:0] mem [2048];
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] exp_pc, exp_instr, exp_rd_data;  // last stepped instruction
    logic [4:0]  exp_rd;
    logic        exp_load, exp_store, exp_unknown;
    logic [31:0] st_addr, st_data;

    // depends on every address bit
    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] a;
        a = 32'(idx) << 2;
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] alu_calc(input logic [2:0] f3, input logic alt,
        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // x31 holds the data window base for every lw and sw
    task automatic gen_program();
        int i;
        int kind;
        int k;
        int span;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        for (int w = 0; w < 2048; w++) begin
            mem[w] = fill_word(w);
        end
        for (int r = 0; r < 32; r++) begin
            regs[r] = 32'd0;
        end
        pc = 32'd0;
        mem[0] = {20'h00001, 5'd31, OPC_LUI};
        i = 1;
        while (i < N_INSTR) begin
            kind = int'($urandom % 11);
            rd   = 5'($urandom % 31);  // x31 reserved
            rs1  = 5'($urandom);
            rs2  = 5'($urandom);
            f3   = 3'($urandom);
            span = N_INSTR - i;
            if (span > 8) span = 8;
            k = 1 + int'($urandom % span);  // forward, at most to the final jump
            case (kind)
                0, 1, 2: begin
                    mem[i] = enc_r(((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2 == 1) ?
                                   7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP);
                end
                3, 4: begin
                    imm = 12'($urandom);
                    if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                    if (f3 == 3'd5) imm = {imm[10] ? 7'h20 : 7'h00, imm[4:0]};
                    mem[i] = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
                end
                5: mem[i] = {20'($urandom), rd, ($urandom % 2 == 1) ? OPC_LUI : OPC_AUIPC};
                6: begin
                    if (f3 == 3'd2 || f3 == 3'd3) f3 = 3'd0;  // unused branch codes
                    mem[i] = enc_b(13'(k * 4), rs2, rs1, f3);
                end
                7: mem[i] = enc_j(21'(k * 4), rd);
                8: begin
                    imm = 12'(($urandom % 64) * 4);
                    if ($urandom % 2 == 1) begin
                        mem[i] = enc_i(imm, 5'd31, 3'b010, rd, OPC_LOAD);
                    end else begin
                        mem[i] = enc_s(imm, rs2, 5'd31);
                    end
                end
                9: begin
                    imm = 12'((i + k) * 4) | {11'd0, 1'($urandom)};  // bit 0 gets cleared
                    mem[i] = enc_i(imm, 5'd0, 3'b000, rd, OPC_JALR);
                end
                default: mem[i] = {20'($urandom), rd, 7'b0001011};  // custom-0, not decoded
            endcase
            i++;
        end
        mem[N_INSTR] = enc_j(21'd0, 5'd0);  // self-jump ends the program
    endtask

    task automatic step();
        logic [31:0] ins, a, b, ival, sval, res, nxt, addr;
        logic [4:0]  rd;
        logic        wr;
        ins  = mem[pc[12:2]];
        a    = regs[ins[19:15]];
        b    = regs[ins[24:20]];
        ival = {{20{ins[31]}}, ins[31:20]};
        sval = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        rd   = ins[11:7];
        nxt  = pc + 32'd4;
        res  = 32'd0;
        wr   = 1'b0;
        exp_load    = 1'b0;
        exp_store   = 1'b0;
        exp_unknown = 1'b0;
        case (ins[6:0])
            OPC_LUI: begin
                res = {ins[31:12], 12'd0};
                wr  = 1'b1;
            end
            OPC_AUIPC: begin
                res = pc + {ins[31:12], 12'd0};
                wr  = 1'b1;
            end
            OPC_JAL: begin
                res = pc + 32'd4;
                wr  = 1'b1;
                nxt = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                res = pc + 32'd4;
                wr  = 1'b1;
                nxt = (a + ival) & ~32'd1;
            end
            OPC_BRANCH: begin
                if (branch_taken(ins[14:12], a, b)) begin
                    nxt = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OPC_LOAD: begin
                addr     = a + ival;
                res      = mem[addr[12:2]];
                wr       = 1'b1;
                exp_load = 1'b1;
            end
            OPC_STORE: begin
                addr            = a + sval;
                mem[addr[12:2]] = b;
                st_addr         = addr;
                st_data         = b;
                exp_store       = 1'b1;
            end
            OPC_OP_IMM: begin
                res = alu_calc(ins[14:12], ins[14:12] == 3'd5 && ins[30], a, ival);
                wr  = 1'b1;
            end
            OPC_OP: begin
                res = alu_calc(ins[14:12], ins[30], a, b);
                wr  = 1'b1;
            end
            default: exp_unknown = 1'b1;  // retires as a no-op
        endcase
        exp_rd      = (wr && rd != 5'd0) ? rd : 5'd0;
        exp_rd_data = (exp_rd != 5'd0) ? res : 32'd0;
        if (exp_rd != 5'd0) regs[rd] = res;
        exp_pc    = pc;
        exp_instr = ins;
        pc        = nxt;
    endtask

endmodule

`default_nettype wire

/* verification/rv_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    localparam int N_INSTR     = 200;
    localparam int WATCHDOG_NS = (N_INSTR * 20 + 10) * 100;  // instr x cycles x period

    logic        clk;
    logic        rst;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    retire_t     retire;
    logic [31:0] mem [2048];     // memory seen by the core
    logic [31:0] wr_addr_q [$];  // completed axi writes
    logic [31:0] wr_data_q [$];
    int          errors, retired, loads, stores, ar_count, aw_count, w_count;
    int          ar_wait, r_wait, aw_wait, w_wait, b_wait;
    logic        ar_hs, r_hs, aw_hs, w_hs, b_hs;
    logic        r_pend, aw_got, w_got, fetched, done;
    logic [31:0] r_word, aw_addr, w_data;

    rv_core_top #(.RESET_PC(32'h0000_0000)) rv_core_top_i (
        .clk      (clk),
        .rst      (rst),
        .axil_rsp (axil_rsp),
        .axil_req (axil_req),
        .retire   (retire)
    );

    rv_iss_model #(.N_INSTR(N_INSTR)) model_i ();

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_retire();
        model_i.step();
        retired++;
        compare_word("retire_pc", model_i.exp_pc, retire.pc);
        compare_word("retire_instr", model_i.exp_instr, retire.instr);
        compare_word("retire_rd", 32'(model_i.exp_rd), 32'(retire.rd));
        compare_word("retire_rd_data", model_i.exp_rd_data, retire.rd_data);
        if (retire.rd == 5'd0 && retire.rd_data != 32'd0) begin
            compare_word("rd0_data", 32'd0, retire.rd_data);
        end
        if (model_i.exp_unknown && retire.rd != 5'd0) begin
            compare_word("unknown_opcode_rd", 32'd0, 32'(retire.rd));
        end
        if (model_i.exp_load) loads++;
        if (model_i.exp_store) begin
            stores++;
            if (wr_addr_q.size() == 0) begin
                $display("Error: a store retired without any AXI write");
                errors++;
            end else begin
                compare_word("store_addr", model_i.st_addr, wr_addr_q.pop_front());
                compare_word("store_data", model_i.st_data, wr_data_q.pop_front());
            end
        end
        if (retire.pc == 32'(N_INSTR * 4)) done = 1'b1;  // reached the self-jump
    endtask

    // random 0 to 3 cycle stalls on every ready and valid
    task automatic drive_memory();
        if (ar_hs) begin
            axil_rsp.arready = 1'b0;
            ar_wait = $urandom % 4;
            r_pend  = 1'b1;
            r_wait  = $urandom % 4;
        end else if (ar_wait > 0) ar_wait--;
        else axil_rsp.arready = 1'b1;
        if (r_hs) begin
            axil_rsp.rvalid = 1'b0;
            r_pend = 1'b0;
        end else if (r_pend && !axil_rsp.rvalid) begin
            if (r_wait > 0) r_wait--;
            else begin
                axil_rsp.rvalid = 1'b1;
                axil_rsp.rdata  = r_word;
            end
        end
        if (aw_hs) begin
            axil_rsp.awready = 1'b0;
            aw_wait = $urandom % 4;
            aw_got  = 1'b1;
            b_wait  = $urandom % 4;
        end else if (aw_wait > 0) aw_wait--;
        else axil_rsp.awready = 1'b1;
        if (w_hs) begin
            axil_rsp.wready = 1'b0;
            w_wait = $urandom % 4;
            w_got  = 1'b1;
            b_wait = $urandom % 4;
        end else if (w_wait > 0) w_wait--;
        else axil_rsp.wready = 1'b1;
        if (b_hs) axil_rsp.bvalid = 1'b0;
        else if (aw_got && w_got) begin
            if (b_wait > 0) b_wait--;
            else begin
                mem[aw_addr[12:2]] = w_data;
                wr_addr_q.push_back(aw_addr);
                wr_data_q.push_back(w_data);
                aw_got = 1'b0;
                w_got  = 1'b0;
                axil_rsp.bvalid = 1'b1;
            end
        end
    endtask

    // sample mid cycle and drive just after the rising edge
    always begin
        @(negedge clk);
        ar_hs = axil_req.arvalid && axil_rsp.arready;
        r_hs  = axil_req.rready && axil_rsp.rvalid;
        aw_hs = axil_req.awvalid && axil_rsp.awready;
        w_hs  = axil_req.wvalid && axil_rsp.wready;
        b_hs  = axil_req.bready && axil_rsp.bvalid;
        if (ar_hs) r_word = mem[axil_req.araddr[12:2]];
        if (aw_hs) aw_addr = axil_req.awaddr;
        if (w_hs) w_data = axil_req.wdata;
        if (!rst && !done) begin
            if (!fetched) begin
                if (axil_req.awvalid || axil_req.wvalid || retire.valid) begin
                    $display("Error: write valid or retire pulse before the first fetch");
                    errors++;
                end
                if (ar_hs) compare_word("reset_pc", 32'h0000_0000, axil_req.araddr);
                if (r_hs) fetched = 1'b1;
            end
            if (ar_hs) ar_count++;
            if (aw_hs) aw_count++;
            if (w_hs) begin
                w_count++;
                compare_word("store_wstrb", 32'h0000_000f, 32'(axil_req.wstrb));  // all lanes
            end
            if (retire.valid) check_retire();
        end
        @(posedge clk);
        #10;
        drive_memory();
    end

    initial begin
        #WATCHDOG_NS;
        $display("Core stopped retiring instructions before the end of the program");
        $display("errors: %0d, retired: %0d", errors + 1, retired);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h4a0a));
        rst      = 1'b1;
        axil_rsp = '0;
        errors   = 0;
        retired  = 0;
        loads    = 0;
        stores   = 0;
        ar_count = 0;
        aw_count = 0;
        w_count  = 0;
        ar_wait  = 0;
        r_wait   = 0;
        aw_wait  = 0;
        w_wait   = 0;
        b_wait   = 0;
        r_pend   = 1'b0;
        aw_got   = 1'b0;
        w_got    = 1'b0;
        fetched  = 1'b0;
        done     = 1'b0;
        r_word   = 32'd0;
        aw_addr  = 32'd0;
        w_data   = 32'd0;
        model_i.gen_program();
        for (int i = 0; i < 2048; i++) begin
            mem[i] = model_i.mem[i];
        end
        repeat (2) @(posedge clk);
        #10;
        rst = 1'b0;
        wait (done);
        compare_word("axi_reads", 32'(retired + loads), 32'(ar_count));
        compare_word("axi_aw_writes", 32'(stores), 32'(aw_count));
        compare_word("axi_w_writes", 32'(stores), 32'(w_count));
        compare_word("unmatched_writes", 32'd0, 32'(wr_addr_q.size()));
        $display("errors: %0d, retired: %0d", errors, retired);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_pc.sv
logic/rv_control_fsm.sv
logic/rv_core_top.sv
verification/rv_iss_model.sv
verification/rv_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the core testbench with Verilator

rm -f sim.log

verilator --binary --timing --assert --top-module rv_core_tb -f filelist.f -o rv_core_sim \
    && ./obj_dir/rv_core_sim > sim.log 2>&1 \
    || echo "test failed" >> sim.log

cat sim.log

grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
